//--- Makefile
SIM        := verilator
TOP        := aluCluster_tb
FILELIST   := verilog.f
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  logic              CLK,
  input  logic              RST,
  input  logic              headValid,
  input  aluOpPkg::aluOp_e  headOp,
  input  aluOpPkg::word_t   headA,
  input  aluOpPkg::word_t   headB,
  input  aluOpPkg::shamt_t  headShamt,
  output logic              pop,
  output logic              resValid,
  output aluOpPkg::word_t   resData,
  output logic              resOv
);

  aluOpPkg::dword_t hilo;
  aluOpPkg::word_t  hi;
  aluOpPkg::word_t  lo;

  aluOpPkg::word_t  sum;
  aluOpPkg::word_t  diff;
  logic signed [63:0] prodS;
  aluOpPkg::dword_t   prodU;

  aluOpPkg::word_t  resNext;
  logic             ovNext;
  logic             hiloAccess;
  logic             writesReg;
  logic             isDiv;

  logic             divBusy;
  logic             divDone;
  aluOpPkg::word_t  quotient;
  aluOpPkg::word_t  remainder;

  assign hi = hilo[63:32];
  assign lo = hilo[31:0];

  // Shared arithmetic
  assign sum   = headA + headB;
  assign diff  = headA - headB;
  // Operands sign extended to 64 bits before the multiply
  assign prodS = $signed(headA) * $signed(headB);
  assign prodU = headA * headB;

  // Anything that reads or writes HI/LO
  always_comb begin
    case (headOp)
      aluOpPkg::OpMfhi, aluOpPkg::OpMflo,
      aluOpPkg::OpMult, aluOpPkg::OpMultu,
      aluOpPkg::OpMadd, aluOpPkg::OpMaddu,
      aluOpPkg::OpMsub, aluOpPkg::OpMsubu,
      aluOpPkg::OpMthi, aluOpPkg::OpMtlo,
      aluOpPkg::OpDiv,  aluOpPkg::OpDivu: hiloAccess = 1'b1;
      default:                           hiloAccess = 1'b0;
    endcase
  end

  // HI/LO-only writers produce no register result
  always_comb begin
    case (headOp)
      aluOpPkg::OpMult, aluOpPkg::OpMultu,
      aluOpPkg::OpMadd, aluOpPkg::OpMaddu,
      aluOpPkg::OpMsub, aluOpPkg::OpMsubu,
      aluOpPkg::OpMthi, aluOpPkg::OpMtlo,
      aluOpPkg::OpDiv,  aluOpPkg::OpDivu: writesReg = 1'b0;
      default:                           writesReg = 1'b1;
    endcase
  end

  // Hold a HI/LO user at the head until the divide has landed
  assign pop = headValid & ~(hiloAccess & divBusy);

  // Divider is never started while busy, the stall sees to that
  assign isDiv = (headOp == aluOpPkg::OpDiv) | (headOp == aluOpPkg::OpDivu);

  // Register result
  always_comb begin
    case (headOp)
      aluOpPkg::OpAdd,  aluOpPkg::OpAddu: resNext = sum;
      aluOpPkg::OpSub,  aluOpPkg::OpSubu: resNext = diff;
      aluOpPkg::OpAnd:  resNext = headA & headB;
      aluOpPkg::OpOr:   resNext = headA | headB;
      aluOpPkg::OpXor:  resNext = headA ^ headB;
      aluOpPkg::OpNor:  resNext = ~(headA | headB);
      aluOpPkg::OpSll:  resNext = headB << headShamt;
      // Upper half load
      aluOpPkg::OpSllc: resNext = {headB[15:0], 16'b0};
      aluOpPkg::OpSrl:  resNext = headB >> headShamt;
      aluOpPkg::OpSra:  resNext = $signed(headB) >>> headShamt;
      // Variable shifts take the amount from A
      aluOpPkg::OpSllv: resNext = headB << headA[4:0];
      aluOpPkg::OpSrlv: resNext = headB >> headA[4:0];
      aluOpPkg::OpSrav: resNext = $signed(headB) >>> headA[4:0];
      aluOpPkg::OpSlt:  resNext = {31'b0, $signed(headA) < $signed(headB)};
      aluOpPkg::OpSltu: resNext = {31'b0, headA < headB};
      aluOpPkg::OpMul:  resNext = prodS[31:0];
      aluOpPkg::OpMfhi: resNext = hi;
      aluOpPkg::OpMflo: resNext = lo;
      default:          resNext = '0;
    endcase
  end

  // Signed overflow only, unsigned forms never trap
  always_comb begin
    case (headOp)
      aluOpPkg::OpAdd: ovNext = (headA[31] == headB[31]) & (sum[31] != headA[31]);
      aluOpPkg::OpSub: ovNext = (headA[31] != headB[31]) & (diff[31] != headA[31]);
      default:         ovNext = 1'b0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      resValid <= 1'b0;
    end else begin
      resValid <= pop & writesReg;
    end
  end

  always_ff @(posedge CLK) begin
    if (pop) begin
      resData <= resNext;
      resOv   <= ovNext;
    end
  end

  // HI/LO, divide completion first
  always_ff @(posedge CLK) begin
    if (RST) begin
      hilo <= '0;
    end else if (divDone) begin
      hilo <= {remainder, quotient};
    end else if (pop) begin
      case (headOp)
        aluOpPkg::OpMult:  hilo <= prodS;
        aluOpPkg::OpMultu: hilo <= prodU;
        aluOpPkg::OpMadd:  hilo <= hilo + prodS;
        aluOpPkg::OpMaddu: hilo <= hilo + prodU;
        aluOpPkg::OpMsub:  hilo <= hilo - prodS;
        aluOpPkg::OpMsubu: hilo <= hilo - prodU;
        // mthi takes A, mtlo takes B
        aluOpPkg::OpMthi:  hilo <= {headA, lo};
        aluOpPkg::OpMtlo:  hilo <= {hi, headB};
        default:           hilo <= hilo;
      endcase
    end
  end

  divider i_divider (
    .CLK       (CLK),
    .RST       (RST),
    .divStart  (pop & isDiv),
    .divSigned (headOp == aluOpPkg::OpDiv),
    .dividend  (headA),
    .divisor   (headB),
    .divBusy   (divBusy),
    .divDone   (divDone),
    .quotient  (quotient),
    .remainder (remainder)
  );

endmodule

`default_nettype wire

//--- aluCfgPkg.sv
`default_nettype none

package aluCfgPkg;

  // Operation queue entries
  localparam int QueueDepth = 4;

  // Credit counter must reach QueueDepth itself
  typedef logic [$clog2(QueueDepth + 1) - 1:0] credit_t;

  // Read and write index into the queue
  typedef logic [$clog2(QueueDepth) - 1:0] qPtr_t;

  // One quotient bit per iteration
  localparam int DivCycles = 32;

endpackage

`default_nettype wire

//--- aluCluster.sv
`timescale 1ns/100ps
`default_nettype none

module aluCluster (
  input  logic              CLK,
  input  logic              RST,
  input  logic              inValid,
  output logic              inReady,
  input  aluOpPkg::aluOp_e  inOp,
  input  aluOpPkg::word_t   inA,
  input  aluOpPkg::word_t   inB,
  input  aluOpPkg::shamt_t  inShamt,
  output logic              resValid,
  output aluOpPkg::word_t   resData,
  output logic              resOv
);

  // Issue to queue
  logic              pushValid;
  aluOpPkg::aluOp_e  pushOp;
  aluOpPkg::word_t   pushA;
  aluOpPkg::word_t   pushB;
  aluOpPkg::shamt_t  pushShamt;
  logic              creditReturn;

  // Queue to ALU
  logic              headValid;
  aluOpPkg::aluOp_e  headOp;
  aluOpPkg::word_t   headA;
  aluOpPkg::word_t   headB;
  aluOpPkg::shamt_t  headShamt;
  logic              pop;

  opIssue i_opIssue (
    .CLK          (CLK),
    .RST          (RST),
    .inValid      (inValid),
    .inReady      (inReady),
    .inOp         (inOp),
    .inA          (inA),
    .inB          (inB),
    .inShamt      (inShamt),
    .creditReturn (creditReturn),
    .pushValid    (pushValid),
    .pushOp       (pushOp),
    .pushA        (pushA),
    .pushB        (pushB),
    .pushShamt    (pushShamt)
  );

  opQueue i_opQueue (
    .CLK          (CLK),
    .RST          (RST),
    .pushValid    (pushValid),
    .pushOp       (pushOp),
    .pushA        (pushA),
    .pushB        (pushB),
    .pushShamt    (pushShamt),
    .pop          (pop),
    .headValid    (headValid),
    .headOp       (headOp),
    .headA        (headA),
    .headB        (headB),
    .headShamt    (headShamt),
    .creditReturn (creditReturn)
  );

  alu i_alu (
    .CLK       (CLK),
    .RST       (RST),
    .headValid (headValid),
    .headOp    (headOp),
    .headA     (headA),
    .headB     (headB),
    .headShamt (headShamt),
    .pop       (pop),
    .resValid  (resValid),
    .resData   (resData),
    .resOv     (resOv)
  );

endmodule

`default_nettype wire

//--- aluCluster_checker.sv
`timescale 1ns/100ps
`default_nettype none

module aluCluster_checker (
  input logic               CLK,
  input logic               RST,
  input logic               pushValid,
  input logic               pop,
  input aluCfgPkg::credit_t count
);

  // Full queue as a count value
  localparam aluCfgPkg::credit_t FullCount = aluCfgPkg::credit_t'(aluCfgPkg::QueueDepth);

  // Failed properties, read back by the testbench
  int violations = 0;

  // Credits keep every push off a full queue
  noPushWhenFull: assert property (
    @(posedge CLK) disable iff (RST) pushValid |-> (count != FullCount)
  ) else begin
    violations++;
    $error("push into a full operation queue");
  end

  // ALU only pops an occupied queue
  noPopWhenEmpty: assert property (
    @(posedge CLK) disable iff (RST) pop |-> (count != '0)
  ) else begin
    violations++;
    $error("pop from an empty operation queue");
  end

  occupancyBound: assert property (
    @(posedge CLK) disable iff (RST) count <= FullCount
  ) else begin
    violations++;
    $error("queue occupancy above its depth");
  end

endmodule

`default_nettype wire

//--- aluCluster_tb.sv
`timescale 1ns/100ps
`default_nettype none

module aluCluster_tb;

  // Longest wait for one handshake or a full drain, in cycles
  localparam int WaitLimit = 400;

  logic              CLK;
  logic              RST;
  logic              inValid;
  logic              inReady;
  aluOpPkg::aluOp_e  inOp;
  aluOpPkg::word_t   inA;
  aluOpPkg::word_t   inB;
  aluOpPkg::shamt_t  inShamt;
  logic              resValid;
  aluOpPkg::word_t   resData;
  logic              resOv;

  // Expected results in issue order
  aluOpPkg::word_t   expData [$];
  logic              expOv [$];

  aluOpPkg::dword_t  modelHiLo;
  aluOpPkg::word_t   rngState;
  int                valueErrors;
  int                orderErrors;
  int                flowErrors;
  int                timeoutErrors;
  int                resultCount;
  int                expectCount;
  logic              sawNotReady;

  aluCluster i_aluCluster (
    .CLK      (CLK),
    .RST      (RST),
    .inValid  (inValid),
    .inReady  (inReady),
    .inOp     (inOp),
    .inA      (inA),
    .inB      (inB),
    .inShamt  (inShamt),
    .resValid (resValid),
    .resData  (resData),
    .resOv    (resOv)
  );

  // Occupancy checks inside the queue
  bind opQueue aluCluster_checker i_aluCluster_checker (
    .CLK       (CLK),
    .RST       (RST),
    .pushValid (pushValid),
    .pop       (pop),
    .count     (count)
  );

  always #10 CLK = ~CLK;

  // Xorshift generator, state advances on every call
  function automatic aluOpPkg::word_t nextRand();
    aluOpPkg::word_t x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // HI/LO-only operations give no register result
  function automatic logic writesRegister(input aluOpPkg::aluOp_e op);
    case (op)
      aluOpPkg::OpMult, aluOpPkg::OpMultu, aluOpPkg::OpMadd, aluOpPkg::OpMaddu,
      aluOpPkg::OpMsub, aluOpPkg::OpMsubu, aluOpPkg::OpMthi, aluOpPkg::OpMtlo,
      aluOpPkg::OpDiv, aluOpPkg::OpDivu: return 1'b0;
      default: return 1'b1;
    endcase
  endfunction

  function automatic aluOpPkg::word_t refResult(
    input aluOpPkg::aluOp_e op,
    input aluOpPkg::word_t  a,
    input aluOpPkg::word_t  b,
    input aluOpPkg::shamt_t sh,
    input aluOpPkg::dword_t hiLo
  );
    longint          prod;
    aluOpPkg::word_t r;
    prod = longint'($signed(a)) * longint'($signed(b));
    case (op)
      aluOpPkg::OpAdd, aluOpPkg::OpAddu: r = a + b;
      aluOpPkg::OpSub, aluOpPkg::OpSubu: r = a - b;
      aluOpPkg::OpAnd:  r = a & b;
      aluOpPkg::OpOr:   r = a | b;
      aluOpPkg::OpXor:  r = a ^ b;
      aluOpPkg::OpNor:  r = ~(a | b);
      aluOpPkg::OpSll:  r = b << sh;
      // Low half of B moved to the top
      aluOpPkg::OpSllc: r = b << 16;
      aluOpPkg::OpSrl:  r = b >> sh;
      aluOpPkg::OpSra:  r = aluOpPkg::word_t'($signed(b) >>> sh);
      aluOpPkg::OpSllv: r = b << a[4:0];
      aluOpPkg::OpSrlv: r = b >> a[4:0];
      aluOpPkg::OpSrav: r = aluOpPkg::word_t'($signed(b) >>> a[4:0]);
      // Flipping the sign bits turns a signed compare into an unsigned one
      aluOpPkg::OpSlt:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
      aluOpPkg::OpSltu: r = (a < b) ? 32'd1 : 32'd0;
      aluOpPkg::OpMul:  r = prod[31:0];
      aluOpPkg::OpMfhi: r = hiLo[63:32];
      aluOpPkg::OpMflo: r = hiLo[31:0];
      default:          r = '0;
    endcase
    return r;
  endfunction

  // Overflow when the exact sum leaves the signed 32-bit range
  function automatic logic refOverflow(
    input aluOpPkg::aluOp_e op,
    input aluOpPkg::word_t  a,
    input aluOpPkg::word_t  b
  );
    longint wide;
    case (op)
      aluOpPkg::OpAdd: wide = longint'($signed(a)) + longint'($signed(b));
      aluOpPkg::OpSub: wide = longint'($signed(a)) - longint'($signed(b));
      default:         wide = 0;
    endcase
    return (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
  endfunction

  // Returns {remainder, quotient}
  function automatic aluOpPkg::dword_t divModel(
    input logic            signedOp,
    input aluOpPkg::word_t a,
    input aluOpPkg::word_t b
  );
    logic            negA;
    logic            negB;
    aluOpPkg::word_t magA;
    aluOpPkg::word_t magB;
    aluOpPkg::word_t q;
    aluOpPkg::word_t r;
    negA = signedOp & a[31];
    negB = signedOp & b[31];
    magA = negA ? -a : a;
    magB = negB ? -b : b;
    // Zero divisor: all-ones magnitude, dividend left as remainder
    if (magB == '0) begin
      q = '1;
      r = magA;
    end else begin
      q = magA / magB;
      r = magA % magB;
    end
    if (negA ^ negB) begin
      q = -q;
    end
    if (negA) begin
      r = -r;
    end
    return {r, q};
  endfunction

  function automatic aluOpPkg::dword_t nextHiLo(
    input aluOpPkg::aluOp_e op,
    input aluOpPkg::word_t  a,
    input aluOpPkg::word_t  b,
    input aluOpPkg::dword_t hiLo
  );
    aluOpPkg::dword_t sProd;
    aluOpPkg::dword_t uProd;
    aluOpPkg::dword_t n;
    sProd = aluOpPkg::dword_t'(longint'($signed(a)) * longint'($signed(b)));
    uProd = {32'b0, a} * {32'b0, b};
    case (op)
      aluOpPkg::OpMult:  n = sProd;
      aluOpPkg::OpMultu: n = uProd;
      aluOpPkg::OpMadd:  n = hiLo + sProd;
      aluOpPkg::OpMaddu: n = hiLo + uProd;
      aluOpPkg::OpMsub:  n = hiLo - sProd;
      aluOpPkg::OpMsubu: n = hiLo - uProd;
      aluOpPkg::OpMthi:  n = {a, hiLo[31:0]};
      aluOpPkg::OpMtlo:  n = {hiLo[63:32], b};
      aluOpPkg::OpDiv:   n = divModel(1'b1, a, b);
      aluOpPkg::OpDivu:  n = divModel(1'b0, a, b);
      default:           n = hiLo;
    endcase
    return n;
  endfunction

  // Hold one operation on the inputs until it is taken
  task automatic issueOp(
    input aluOpPkg::aluOp_e op,
    input aluOpPkg::word_t  a,
    input aluOpPkg::word_t  b,
    input aluOpPkg::shamt_t sh
  );
    int waited;
    waited  = 0;
    inValid = 1'b1;
    inOp    = op;
    inA     = a;
    inB     = b;
    inShamt = sh;
    // inReady moves only on an edge, so it is settled here
    while (!inReady && waited < WaitLimit) begin
      sawNotReady = 1'b1;
      @(posedge CLK);
      #1;
      waited++;
    end
    if (!inReady) begin
      $display("Timeout: operation %s was never accepted", op.name());
      timeoutErrors++;
      inValid = 1'b0;
    end else begin
      @(posedge CLK);
      #1;
      inValid = 1'b0;
      if (writesRegister(op)) begin
        expData.push_back(refResult(op, a, b, sh, modelHiLo));
        expOv.push_back(refOverflow(op, a, b));
        expectCount++;
      end
      modelHiLo = nextHiLo(op, a, b, modelHiLo);
    end
  endtask

  task automatic waitDrain();
    int waited;
    waited = 0;
    while (expData.size() != 0 && waited < WaitLimit) begin
      @(posedge CLK);
      #1;
      waited++;
    end
    if (expData.size() != 0) begin
      $display("Timeout: %0d expected results never arrived", expData.size());
      timeoutErrors++;
      expData.delete();
      expOv.delete();
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge CLK) begin : compareResults
    aluOpPkg::word_t wantData;
    logic            wantOv;
    if (!RST && resValid) begin
      resultCount++;
      if (expData.size() == 0) begin
        $display("A result arrived with no operation outstanding");
        orderErrors++;
      end else begin
        wantData = expData.pop_front();
        wantOv   = expOv.pop_front();
        assert (resData === wantData) else begin
          $display("Fail resData: got %h, expected %h", resData, wantData);
          valueErrors++;
        end
        assert (resOv === wantOv) else begin
          $display("Fail resOv: got %h, expected %h", resOv, wantOv);
          valueErrors++;
        end
      end
    end
  end

  initial begin : stimulus
    aluOpPkg::aluOp_e regOps [18];
    aluOpPkg::aluOp_e hiloOps [8];
    aluOpPkg::aluOp_e op;
    aluOpPkg::word_t  a;
    aluOpPkg::word_t  b;
    int               queueErrors;
    int               errorTotal;
    regOps = '{aluOpPkg::OpAdd, aluOpPkg::OpAddu, aluOpPkg::OpSub, aluOpPkg::OpSubu,
               aluOpPkg::OpAnd, aluOpPkg::OpOr, aluOpPkg::OpXor, aluOpPkg::OpNor,
               aluOpPkg::OpSll, aluOpPkg::OpSllc, aluOpPkg::OpSrl, aluOpPkg::OpSra,
               aluOpPkg::OpSllv, aluOpPkg::OpSrlv, aluOpPkg::OpSrav, aluOpPkg::OpSlt,
               aluOpPkg::OpSltu, aluOpPkg::OpMul};
    hiloOps = '{aluOpPkg::OpMult, aluOpPkg::OpMultu, aluOpPkg::OpMadd, aluOpPkg::OpMaddu,
                aluOpPkg::OpMsub, aluOpPkg::OpMsubu, aluOpPkg::OpMthi, aluOpPkg::OpMtlo};
    CLK           = 1'b0;
    RST           = 1'b1;
    inValid       = 1'b0;
    inOp          = aluOpPkg::OpAdd;
    inA           = '0;
    inB           = '0;
    inShamt       = '0;
    rngState      = 32'h1cd049bd;
    modelHiLo     = '0;
    valueErrors   = 0;
    orderErrors   = 0;
    flowErrors    = 0;
    timeoutErrors = 0;
    resultCount   = 0;
    expectCount   = 0;
    sawNotReady   = 1'b0;
    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Idle state straight after reset
    assert (resValid === 1'b0) else begin
      $display("Fail resValid: got %h, expected %h", resValid, 1'b0);
      valueErrors++;
    end
    assert (inReady === 1'b1) else begin
      $display("Fail inReady: got %h, expected %h", inReady, 1'b1);
      valueErrors++;
    end

    // Overflow corners, then random register operations
    issueOp(aluOpPkg::OpAdd, 32'h7fff_ffff, 32'h0000_0001, '0);
    issueOp(aluOpPkg::OpAddu, 32'h7fff_ffff, 32'h0000_0001, '0);
    issueOp(aluOpPkg::OpSub, 32'h8000_0000, 32'h0000_0001, '0);
    issueOp(aluOpPkg::OpSubu, 32'h8000_0000, 32'h0000_0001, '0);
    issueOp(aluOpPkg::OpAdd, 32'h8000_0000, 32'h8000_0000, '0);
    for (int i = 0; i < 80; i++) begin
      op = regOps[nextRand() % 32'd18];
      a  = nextRand();
      b  = nextRand();
      issueOp(op, a, b, aluOpPkg::shamt_t'(nextRand()));
    end
    waitDrain();

    // Every HI/LO writer, each read back through mfhi and mflo
    for (int r = 0; r < 3; r++) begin
      for (int j = 0; j < 8; j++) begin
        a = nextRand();
        b = nextRand();
        issueOp(hiloOps[j], a, b, '0);
        issueOp(aluOpPkg::OpMfhi, '0, '0, '0);
        issueOp(aluOpPkg::OpMflo, '0, '0, '0);
      end
    end
    waitDrain();

    // Divides with random, zero, negative and small divisors
    for (int i = 0; i < 16; i++) begin
      op = (i < 8) ? aluOpPkg::OpDiv : aluOpPkg::OpDivu;
      a  = nextRand();
      case (i % 4)
        0:       b = nextRand();
        1:       b = '0;
        2:       b = nextRand() | 32'h8000_0000;
        default: b = nextRand() >> (i + 8);
      endcase
      issueOp(op, a, b, '0);
      issueOp(aluOpPkg::OpMfhi, '0, '0, '0);
      issueOp(aluOpPkg::OpMflo, '0, '0, '0);
    end
    issueOp(aluOpPkg::OpDiv, 32'h8000_0000, 32'hffff_ffff, '0);
    issueOp(aluOpPkg::OpMfhi, '0, '0, '0);
    issueOp(aluOpPkg::OpMflo, '0, '0, '0);
    waitDrain();

    // Independent work flows past a running divide
    issueOp(aluOpPkg::OpDivu, nextRand(), nextRand() >> 12, '0);
    issueOp(aluOpPkg::OpAdd, nextRand(), nextRand(), '0);
    issueOp(aluOpPkg::OpXor, nextRand(), nextRand(), '0);
    issueOp(aluOpPkg::OpSll, '0, nextRand(), 5'd7);
    issueOp(aluOpPkg::OpMfhi, '0, '0, '0);
    issueOp(aluOpPkg::OpMflo, '0, '0, '0);
    waitDrain();

    // mfhi stuck at the head, burst behind it runs out of credits
    sawNotReady = 1'b0;
    issueOp(aluOpPkg::OpDiv, nextRand(), nextRand(), '0);
    issueOp(aluOpPkg::OpMfhi, '0, '0, '0);
    for (int i = 0; i < 10; i++) begin
      op = regOps[nextRand() % 32'd18];
      a  = nextRand();
      b  = nextRand();
      issueOp(op, a, b, aluOpPkg::shamt_t'(nextRand()));
    end
    assert (sawNotReady) else begin
      $display("inReady never dropped while the queue was blocked by a divide");
      flowErrors++;
    end
    waitDrain();

    // Quiet period to catch stray results
    repeat (10) @(posedge CLK);
    assert (resultCount == expectCount) else begin
      $display("Fail resultCount: got %h, expected %h", resultCount, expectCount);
      orderErrors++;
    end

    queueErrors = i_aluCluster.i_opQueue.i_aluCluster_checker.violations;
    errorTotal  = valueErrors + orderErrors + flowErrors + timeoutErrors + queueErrors;
    $display("Errors: %0d value, %0d order, %0d flow, %0d timeout, %0d queue",
             valueErrors, orderErrors, flowErrors, timeoutErrors, queueErrors);
    if (errorTotal == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- aluOpPkg.sv
`default_nettype none

package aluOpPkg;

  // Operand and result word
  typedef logic [31:0] word_t;

  // HI/LO pair or full product
  typedef logic [63:0] dword_t;

  // Immediate shift amount
  typedef logic [4:0] shamt_t;

  // Execute operations, 30 codes in 5 bits
  typedef enum logic [4:0] {
    OpAdd,
    OpAddu,
    OpSub,
    OpSubu,
    OpAnd,
    OpOr,
    OpXor,
    OpNor,
    OpSll,
    OpSllc,
    OpSrl,
    OpSra,
    OpSllv,
    OpSrlv,
    OpSrav,
    OpSlt,
    OpSltu,
    OpMul,
    OpMfhi,
    OpMflo,
    OpMult,
    OpMultu,
    OpMadd,
    OpMaddu,
    OpMsub,
    OpMsubu,
    OpMthi,
    OpMtlo,
    OpDiv,
    OpDivu
  } aluOp_e;

endpackage

`default_nettype wire

//--- divider.sv
`timescale 1ns/100ps
`default_nettype none

module divider (
  input  logic             CLK,
  input  logic             RST,
  input  logic             divStart,
  input  logic             divSigned,
  input  aluOpPkg::word_t  dividend,
  input  aluOpPkg::word_t  divisor,
  output logic             divBusy,
  output logic             divDone,
  output aluOpPkg::word_t  quotient,
  output aluOpPkg::word_t  remainder
);

  typedef enum logic {DivIdle, DivRun} divState_e;

  divState_e state;
  logic [$clog2(aluCfgPkg::DivCycles) - 1:0] iter;

  aluOpPkg::word_t quo;
  aluOpPkg::word_t rem;
  aluOpPkg::word_t dvsr;
  logic            negQ;
  logic            negR;

  logic            dividendNeg;
  logic            divisorNeg;
  logic [32:0]     remShift;

  assign dividendNeg = divSigned & dividend[31];
  assign divisorNeg  = divSigned & divisor[31];

  // Next partial remainder before the trial subtract
  assign remShift = {rem, quo[31]};

  // Busy stays up through the done cycle so HI/LO readers keep waiting
  assign divBusy = (state == DivRun);

  // Sign fix on the magnitudes, truncating toward zero
  assign quotient  = negQ ? -quo : quo;
  assign remainder = negR ? -rem : rem;

  always_ff @(posedge CLK) begin
    if (RST) begin
      state   <= DivIdle;
      iter    <= '0;
      divDone <= 1'b0;
    end else begin
      divDone <= 1'b0;
      case (state)
        DivIdle: begin
          iter <= '0;
          if (divStart) begin
            state <= DivRun;
          end
        end
        DivRun: begin
          if (divDone) begin
            state <= DivIdle;
          end else begin
            iter <= iter + 1'b1;
            // Last quotient bit lands on this edge
            if (iter == ($bits(iter))'(aluCfgPkg::DivCycles - 1)) begin
              divDone <= 1'b1;
            end
          end
        end
        default: state <= DivIdle;
      endcase
    end
  end

  // Restoring shift-subtract on magnitudes
  always_ff @(posedge CLK) begin
    if (state == DivIdle && divStart) begin
      quo  <= dividendNeg ? -dividend : dividend;
      dvsr <= divisorNeg ? -divisor : divisor;
      rem  <= '0;
      negQ <= dividendNeg ^ divisorNeg;
      negR <= dividendNeg;
    end else if (state == DivRun && !divDone) begin
      // Zero divisor always subtracts, giving all ones and rem = dividend
      if (remShift >= {1'b0, dvsr}) begin
        rem <= remShift[31:0] - dvsr;
        quo <= {quo[30:0], 1'b1};
      end else begin
        rem <= remShift[31:0];
        quo <= {quo[30:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

//--- opIssue.sv
`timescale 1ns/100ps
`default_nettype none

module opIssue (
  input  logic              CLK,
  input  logic              RST,
  input  logic              inValid,
  output logic              inReady,
  input  aluOpPkg::aluOp_e  inOp,
  input  aluOpPkg::word_t   inA,
  input  aluOpPkg::word_t   inB,
  input  aluOpPkg::shamt_t  inShamt,
  input  logic              creditReturn,
  output logic              pushValid,
  output aluOpPkg::aluOp_e  pushOp,
  output aluOpPkg::word_t   pushA,
  output aluOpPkg::word_t   pushB,
  output aluOpPkg::shamt_t  pushShamt
);

  // Free queue slots as seen from the issue side
  aluCfgPkg::credit_t credits;
  logic               accept;

  // Only take an operation when a queue slot is guaranteed
  assign inReady = (credits != '0);
  assign accept  = inValid & inReady;

  // Spend on accept, refill on return, both may happen together
  always_ff @(posedge CLK) begin
    if (RST) begin
      credits <= aluCfgPkg::credit_t'(aluCfgPkg::QueueDepth);
    end else begin
      case ({accept, creditReturn})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Push strobe follows the accept by one cycle
  always_ff @(posedge CLK) begin
    if (RST) begin
      pushValid <= 1'b0;
    end else begin
      pushValid <= accept;
    end
  end

  // Operation fields held for the queue write
  always_ff @(posedge CLK) begin
    if (accept) begin
      pushOp    <= inOp;
      pushA     <= inA;
      pushB     <= inB;
      pushShamt <= inShamt;
    end
  end

endmodule

`default_nettype wire

//--- opQueue.sv
`timescale 1ns/100ps
`default_nettype none

module opQueue (
  input  logic              CLK,
  input  logic              RST,
  input  logic              pushValid,
  input  aluOpPkg::aluOp_e  pushOp,
  input  aluOpPkg::word_t   pushA,
  input  aluOpPkg::word_t   pushB,
  input  aluOpPkg::shamt_t  pushShamt,
  input  logic              pop,
  output logic              headValid,
  output aluOpPkg::aluOp_e  headOp,
  output aluOpPkg::word_t   headA,
  output aluOpPkg::word_t   headB,
  output aluOpPkg::shamt_t  headShamt,
  output logic              creditReturn
);

  // Entry storage, one array per field
  aluOpPkg::aluOp_e  opMem    [aluCfgPkg::QueueDepth];
  aluOpPkg::word_t   aMem     [aluCfgPkg::QueueDepth];
  aluOpPkg::word_t   bMem     [aluCfgPkg::QueueDepth];
  aluOpPkg::shamt_t  shamtMem [aluCfgPkg::QueueDepth];

  aluCfgPkg::qPtr_t   wrPtr;
  aluCfgPkg::qPtr_t   rdPtr;
  aluCfgPkg::credit_t count;
  logic               popFire;

  // Last slot index, pointers wrap back to zero after it
  localparam aluCfgPkg::qPtr_t LastPtr = aluCfgPkg::qPtr_t'(aluCfgPkg::QueueDepth - 1);

  // Oldest entry is always on the head port
  assign headValid = (count != '0);
  assign headOp    = opMem[rdPtr];
  assign headA     = aMem[rdPtr];
  assign headB     = bMem[rdPtr];
  assign headShamt = shamtMem[rdPtr];

  // A pop request only counts when something is there
  assign popFire = pop & headValid;

  // Write side, credits keep pushes off a full queue
  always_ff @(posedge CLK) begin
    if (pushValid) begin
      opMem[wrPtr]    <= pushOp;
      aMem[wrPtr]     <= pushA;
      bMem[wrPtr]     <= pushB;
      shamtMem[wrPtr] <= pushShamt;
    end
  end

  // Pointers, occupancy and the returned credit
  always_ff @(posedge CLK) begin
    if (RST) begin
      wrPtr        <= '0;
      rdPtr        <= '0;
      count        <= '0;
      creditReturn <= 1'b0;
    end else begin
      if (pushValid) begin
        wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
      end
      if (popFire) begin
        rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
      end
      case ({pushValid, popFire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Each freed slot goes back to the issue stage
      creditReturn <= popFire;
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
aluOpPkg.sv
aluCfgPkg.sv
divider.sv
opIssue.sv
opQueue.sv
alu.sv
aluCluster.sv
aluCluster_checker.sv
aluCluster_tb.sv
